/* chem_sim_top.f */
+incdir+design
+incdir+verif
design/chem_sim_pkg.sv
design/lfsr127_bank.sv
design/reaction_draw.sv
design/reaction_channel.sv
design/step_sequencer.sv
design/species_counter.sv
design/chem_sim_top.sv
verif/chem_sim_tb.sv

/* Bender.yml */
package:
  name: chem_sim

sources:
  - include_dirs:
      - design
    files:
      - design/chem_sim_pkg.sv
      - design/lfsr127_bank.sv
      - design/reaction_draw.sv
      - design/reaction_channel.sv
      - design/step_sequencer.sv
      - design/species_counter.sv
      - design/chem_sim_top.sv
  - target: test
    include_dirs:
      - design
      - verif
    files:
      - verif/chem_sim_tb.sv

/* verif/chem_sim_model.svh */
`ifndef CHEM_SIM_MODEL_SVH
`define CHEM_SIM_MODEL_SVH

////////////////////
// Generator model
////////////////////

// Whole generator as one vector, lane k bit b sits at 8*(k-1)+b
typedef logic [`CHEM_LANES*`CHEM_LANE_W:1] gen_vec_t;

gen_vec_t model_gen [4];  // A conc, A rate, B conc, B rate
conc_t    model_x;        // Expected X count
conc_t    model_y;        // Expected Y count
events_t  model_events;   // Expected events of last step

// Seed plus offset, zero above the top lane
function automatic gen_vec_t gen_load(input seed_t s, input int unsigned ofs);
   seed_t s_ofs;
   s_ofs = s + seed_t'(ofs);
   return {1'b0, s_ofs};
endfunction

function automatic gen_vec_t gen_shift(input gen_vec_t st);
   gen_vec_t nx;
   int       base;
   nx = '0;
   for (int k = 1; k <= `CHEM_LANES; k++)
   begin
      base = `CHEM_LANE_W * (k - 1);
      for (int b = 2; b <= `CHEM_LANE_W; b++)
      begin
         nx[base+b] = st[base+b-1];  // Lane moves up one bit
      end
      if (k == 1)
         nx[base+1] = st[base+7] ^ st[`CHEM_LANE_W*(`CHEM_LANES-1)+7];  // Lane 16 bit 7
      else
         nx[base+1] = st[base+7] ^ st[base];  // Bit 8 of lane below
   end
   nx[`CHEM_LANES*`CHEM_LANE_W] = 1'b0;  // Top lane only 7 bits wide
   return nx;
endfunction

// Bit 7 of each lane, lane 1 on top
function automatic rand_t gen_word(input gen_vec_t st);
   rand_t w;
   for (int i = 1; i <= `CHEM_LANES; i++)
   begin
      w[`CHEM_LANES-i] = st[`CHEM_LANE_W*(i-1)+7];
   end
   return w;
endfunction

////////////////////
// Step model
////////////////////

task automatic model_reset(input seed_t s, input conc_t x0, input conc_t y0);
   model_gen[0] = gen_load(s, `CHEM_SEED_OFS_A_CONC);
   model_gen[1] = gen_load(s, `CHEM_SEED_OFS_A_RATE);
   model_gen[2] = gen_load(s, `CHEM_SEED_OFS_B_CONC);
   model_gen[3] = gen_load(s, `CHEM_SEED_OFS_B_RATE);
   model_x      = x0;
   model_y      = y0;
   model_events = '0;
endtask

// One full step, draws see X from before the update
task automatic model_step(input conc_t k);
   logic hit_a;
   logic hit_b;
   for (int g = 0; g < 4; g++)
   begin
      model_gen[g] = gen_shift(model_gen[g]);
   end
   hit_a = (model_x > gen_word(model_gen[0])) && (k > gen_word(model_gen[1]));
   hit_b = (model_x > gen_word(model_gen[2])) && (k > gen_word(model_gen[3]));
   model_events = hit_a + hit_b;
   if (model_x >= model_events)
      model_x = model_x - model_events;  // Too few molecules means no change
   model_y = model_y + model_events;     // Free to wrap
endtask

`endif

/* verif/chem_sim_tb.sv */
`default_nettype none

`include "chem_sim_consts.svh"

module chem_sim_tb;
   import chem_sim_pkg::*;

   `include "chem_sim_model.svh"

   localparam int TRAJ_STEPS    = 200;
   localparam int ZERO_STEPS    = 50;
   localparam int PAUSE_STEPS   = 100;
   localparam int SAT_STEPS     = 50;
   localparam int TOTAL_STEPS   = TRAJ_STEPS + ZERO_STEPS + PAUSE_STEPS + SAT_STEPS;
   localparam int WATCHDOG_TIME = TOTAL_STEPS * `CHEM_PHASES * 8 * 3;
   localparam int SAMPLE_LIMIT  = 64;  // Cycles allowed between samples

   logic    clock_in;
   logic    reset_in;
   logic    run;
   conc_t   rate;
   conc_t   init_x;
   conc_t   init_y;
   seed_t   seed;
   conc_t   conc_x;
   conc_t   conc_y;
   events_t events;
   logic    sample_valid;

   integer  rng_seed = 32'hd932_afb4;
   int      checks;
   int      errors;
   int      test_checks;
   int      test_errors;
   int      tests;
   string   cur_test;
   seed_t   traj_seed;  // Shared by trajectory and pause tests
   conc_t   traj_rate;
   conc_t   traj_x;
   conc_t   traj_y;

   chem_sim_top DUT (
      .clock_in     (clock_in),
      .reset_in     (reset_in),
      .run          (run),
      .rate         (rate),
      .init_x       (init_x),
      .init_y       (init_y),
      .seed         (seed),
      .conc_x       (conc_x),
      .conc_y       (conc_y),
      .events       (events),
      .sample_valid (sample_valid)
   );

   initial
   begin
      clock_in = 1'b0;
      forever #4 clock_in = ~clock_in;  // Period 8
   end

   ////////////////////
   // Check helpers
   ////////////////////

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      test_checks++;
      assert (actual === expected)
      else
      begin
         errors++;
         test_errors++;
         $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
      end
   endtask

   task automatic check_true(input string what, input bit ok);
      checks++;
      test_checks++;
      assert (ok)
      else
      begin
         errors++;
         test_errors++;
         $display("%s: %s", cur_test, what);
      end
   endtask

   // Load inputs and hold reset for 8 cycles
   task automatic start_test(input string name, input seed_t s, input conc_t k,
                             input conc_t x0, input conc_t y0);
      cur_test    = name;
      test_checks = 0;
      test_errors = 0;
      @(posedge clock_in);
      #1;
      seed     = s;
      rate     = k;
      init_x   = x0;
      init_y   = y0;
      run      = 1'b0;
      reset_in = 1'b1;
      repeat (8) @(posedge clock_in);
      #1;
      reset_in = 1'b0;
      model_reset(s, x0, y0);
   endtask

   task automatic finish_test(input int steps);
      tests++;
      $display("%-12s %0d steps, %0d checks, %0d errors", cur_test, steps, test_checks,
               test_errors);
   endtask

   ////////////////////
   // Step runner
   ////////////////////

   task automatic run_steps(input int nsteps, input bit pause, input bit rate_zero);
      int      samples;
      int      idle;
      int      run_cycles;
      bit      was_paused;
      conc_t   prev_x;
      conc_t   prev_y;
      events_t prev_ev;
      conc_t   start_x;
      conc_t   start_y;
      samples    = 0;
      idle       = 0;
      run_cycles = 0;
      was_paused = 1'b1;  // Release cycle ran with run low
      start_x    = conc_x;
      start_y    = conc_y;
      prev_x     = conc_x;
      prev_y     = conc_y;
      prev_ev    = events;
      while (samples < nsteps && idle < SAMPLE_LIMIT)
      begin
         @(posedge clock_in);
         #1;
         run = pause ? (($random(rng_seed) & 3) != 0) : 1'b1;  // About 3 in 4 running
         @(negedge clock_in);
         if (was_paused)  // Last edge saw run low
         begin
            check_value("paused conc_x", prev_x, conc_x);
            check_value("paused conc_y", prev_y, conc_y);
            check_value("paused events", prev_ev, events);
         end
         if (run)
            run_cycles++;
         else
            check_true("sample_valid high while run is low", !sample_valid);
         if (sample_valid)
         begin
            model_step(rate);
            check_value("events", model_events, events);
            check_value("conc_x", model_x, conc_x);
            check_value("conc_y", model_y, conc_y);
            check_value("cycles per step", `CHEM_PHASES, run_cycles);
            check_true("conc_x went above its start count", conc_x <= start_x);
            if (rate_zero)  // Nothing can fire
            begin
               check_value("zero rate events", 0, events);
               check_value("zero rate conc_x", start_x, conc_x);
               check_value("zero rate conc_y", start_y, conc_y);
            end
            samples++;
            run_cycles = 0;
            idle       = 0;
         end
         else
            idle++;
         was_paused = !run;
         prev_x     = conc_x;
         prev_y     = conc_y;
         prev_ev    = events;
      end
      if (samples < nsteps)
         check_true("no sample_valid seen within the cycle limit", 1'b0);
      finish_test(samples);
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      reset_in = 1'b1;
      run      = 1'b0;
      rate     = '0;
      init_x   = '0;
      init_y   = '0;
      seed     = '0;
      checks   = 0;
      errors   = 0;
      tests    = 0;
      traj_seed = seed_t'({$random(rng_seed), $random(rng_seed), $random(rng_seed),
                           $random(rng_seed)});
      traj_rate = conc_t'($random(rng_seed));
      traj_x    = conc_t'($random(rng_seed));
      traj_y    = conc_t'($random(rng_seed));

      // Counts load their start values, nothing pending
      start_test("reset", traj_seed, traj_rate, traj_x, traj_y);
      run = 1'b1;  // Phase must sit in ADVANCE, so no sample yet
      @(negedge clock_in);
      check_value("conc_x", traj_x, conc_x);
      check_value("conc_y", traj_y, conc_y);
      check_value("sample_valid", 0, sample_valid);
      check_value("events", 0, events);
      finish_test(0);

      start_test("trajectory", traj_seed, traj_rate, traj_x, traj_y);
      run_steps(TRAJ_STEPS, 1'b0, 1'b0);

      start_test("rate_zero", seed_t'({$random(rng_seed), $random(rng_seed),
                 $random(rng_seed), $random(rng_seed)}), '0,
                 conc_t'($random(rng_seed)), conc_t'($random(rng_seed)));
      run_steps(ZERO_STEPS, 1'b0, 1'b1);

      // Same stream as the trajectory, only delayed
      start_test("pause", traj_seed, traj_rate, traj_x, traj_y);
      run_steps(PAUSE_STEPS, 1'b1, 1'b0);

      start_test("saturation", seed_t'({$random(rng_seed), $random(rng_seed),
                 $random(rng_seed), $random(rng_seed)}), 16'hffff,
                 conc_t'($random(rng_seed) & 1), conc_t'($random(rng_seed)));
      run_steps(SAT_STEPS, 1'b0, 1'b0);

      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   // Watchdog, three times the nominal run length
   initial
   begin
      #(WATCHDOG_TIME);
      $display("Simulation timed out after %0d time units in test %s", WATCHDOG_TIME,
               cur_test);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* design/chem_sim_top.sv */
`default_nettype none

`include "chem_sim_consts.svh"

// Stochastic X -> Y simulator
module chem_sim_top (
   input  wire                   clock_in,
   input  wire                   reset_in,
   input  wire                   run,       // Pause when low
   input  wire                   chem_sim_pkg::conc_t rate,
   input  wire                   chem_sim_pkg::conc_t init_x,
   input  wire                   chem_sim_pkg::conc_t init_y,
   input  wire                   chem_sim_pkg::seed_t seed,
   output chem_sim_pkg::conc_t   conc_x,
   output chem_sim_pkg::conc_t   conc_y,
   output chem_sim_pkg::events_t events,    // Events of the last step
   output logic                  sample_valid
);

   wire advance;  // To the generators
   wire draw;     // To the channel
   wire apply;    // To both counters

   step_sequencer u_seq (
      .clock_in     (clock_in),
      .reset_in     (reset_in),
      .run          (run),
      .advance      (advance),
      .draw         (draw),
      .apply        (apply),
      .sample_valid (sample_valid)
   );

   // Reaction probability follows the live count of X
   reaction_channel u_channel (
      .clock_in (clock_in),
      .reset_in (reset_in),
      .seed     (seed),
      .advance  (advance),
      .draw     (draw),
      .conc_x   (conc_x),
      .rate     (rate),
      .events   (events)
   );

   ////////////////////
   // Species
   ////////////////////

   species_counter #(
      .CONSUME (1'b1)
   ) u_count_x (
      .clock_in (clock_in),
      .reset_in (reset_in),
      .init     (init_x),
      .apply    (apply),
      .events   (events),
      .count    (conc_x)
   );

   species_counter #(
      .CONSUME (1'b0)
   ) u_count_y (
      .clock_in (clock_in),
      .reset_in (reset_in),
      .init     (init_y),
      .apply    (apply),
      .events   (events),
      .count    (conc_y)
   );

endmodule

`default_nettype wire

/* design/species_counter.sv */
`default_nettype none

`include "chem_sim_consts.svh"

// Molecule count for one species
module species_counter #(
   parameter bit CONSUME = 1'b1  // 1 for reactant, 0 for product
) (
   input  wire                 clock_in,
   input  wire                 reset_in,
   input  wire                 chem_sim_pkg::conc_t init,    // Count after reset
   input  wire                 apply,                        // Update strobe
   input  wire                 chem_sim_pkg::events_t events,
   output chem_sim_pkg::conc_t count
);
   import chem_sim_pkg::*;

   conc_t delta;       // Events widened to count width
   conc_t next_count;

   assign delta = {{(`CHEM_CONC_W-$bits(events_t)){1'b0}}, events};

   ////////////////////
   // Update rule
   ////////////////////

   always_comb
   begin
      if (CONSUME)
      begin
         // Not enough molecules means no reaction at all
         if (count >= delta)
            next_count = count - delta;
         else
            next_count = count;
      end
      else
      begin
         next_count = count + delta;  // Wraps at 16 bits
      end
   end

   always_ff @(posedge clock_in)
   begin
      if (reset_in)
         count <= init;
      else if (apply)
         count <= next_count;
   end

endmodule

`default_nettype wire

/* design/step_sequencer.sv */
`default_nettype none

`include "chem_sim_consts.svh"

// Cyclic step FSM, ADVANCE -> DRAW -> APPLY -> SAMPLE
module step_sequencer (
   input  wire  clock_in,
   input  wire  reset_in,
   input  wire  run,           // Low freezes the step
   output logic advance,
   output logic draw,
   output logic apply,
   output logic sample_valid
);
   import chem_sim_pkg::*;

   step_phase_t phase;
   step_phase_t phase_next;

   // Next phase wraps after SAMPLE
   assign phase_next = step_phase_t'((int'(phase) + 1) % `CHEM_PHASES);

   ////////////////////
   // Phase register
   ////////////////////

   always_ff @(posedge clock_in)
   begin
      if (reset_in)
         phase <= ADVANCE;
      else if (run)
         phase <= phase_next;  // Hold while paused
   end

   ////////////////////
   // Strobes
   ////////////////////

   // One per phase, silent while paused
   assign advance      = run && (phase == ADVANCE);
   assign draw         = run && (phase == DRAW);
   assign apply        = run && (phase == APPLY);
   assign sample_valid = run && (phase == SAMPLE);  // Once per step

endmodule

`default_nettype wire

/* design/reaction_channel.sv */
`default_nettype none

`include "chem_sim_consts.svh"

// Two independent trials per step, up to two events
module reaction_channel (
   input  wire                   clock_in,
   input  wire                   reset_in,
   input  wire                   chem_sim_pkg::seed_t seed,
   input  wire                   advance,  // Generator shift strobe
   input  wire                   draw,     // Latch the trial results
   input  wire                   chem_sim_pkg::conc_t conc_x,
   input  wire                   chem_sim_pkg::conc_t rate,
   output chem_sim_pkg::events_t events
);
   import chem_sim_pkg::*;

   logic    success_a;
   logic    success_b;
   events_t hits;  // Successes this cycle

   reaction_draw #(
      .CONC_OFS (`CHEM_SEED_OFS_A_CONC),
      .RATE_OFS (`CHEM_SEED_OFS_A_RATE)
   ) u_draw_a (
      .clock_in (clock_in),
      .reset_in (reset_in),
      .seed     (seed),
      .advance  (advance),
      .conc     (conc_x),
      .rate     (rate),
      .success  (success_a)
   );

   reaction_draw #(
      .CONC_OFS (`CHEM_SEED_OFS_B_CONC),
      .RATE_OFS (`CHEM_SEED_OFS_B_RATE)
   ) u_draw_b (
      .clock_in (clock_in),
      .reset_in (reset_in),
      .seed     (seed),
      .advance  (advance),
      .conc     (conc_x),
      .rate     (rate),
      .success  (success_b)
   );

   assign hits = events_t'(success_a) + events_t'(success_b);

   always_ff @(posedge clock_in)
   begin
      if (reset_in)
         events <= '0;
      else if (draw)
         events <= hits;  // Held until the next DRAW
   end

endmodule

`default_nettype wire

/* design/reaction_draw.sv */
`default_nettype none

`include "chem_sim_consts.svh"

// One Monte Carlo trial of X -> Y
module reaction_draw #(
   parameter int unsigned CONC_OFS = `CHEM_SEED_OFS_A_CONC,
   parameter int unsigned RATE_OFS = `CHEM_SEED_OFS_A_RATE
) (
   input  wire                 clock_in,
   input  wire                 reset_in,
   input  wire                 chem_sim_pkg::seed_t seed,
   input  wire                 advance,
   input  wire                 chem_sim_pkg::conc_t conc,  // Current count of X
   input  wire                 chem_sim_pkg::conc_t rate,  // Rate constant k
   output logic                success
);
   import chem_sim_pkg::*;

   rand_t conc_word;  // Compared against the count
   rand_t rate_word;  // Compared against k

   lfsr127_bank #(
      .SEED_OFS (CONC_OFS)
   ) u_conc_gen (
      .clock_in (clock_in),
      .reset_in (reset_in),
      .seed     (seed),
      .advance  (advance),
      .word     (conc_word)
   );

   lfsr127_bank #(
      .SEED_OFS (RATE_OFS)
   ) u_rate_gen (
      .clock_in (clock_in),
      .reset_in (reset_in),
      .seed     (seed),
      .advance  (advance),
      .word     (rate_word)
   );

   // Fires with probability about conc*rate/2^32
   assign success = (conc > conc_word) && (rate > rate_word);

endmodule

`default_nettype wire

/* design/lfsr127_bank.sv */
`default_nettype none

`include "chem_sim_consts.svh"

// 127-bit shift register split into 16 lanes that shift in parallel
module lfsr127_bank #(
   parameter int unsigned SEED_OFS = `CHEM_SEED_OFS_A_CONC
) (
   input  wire                 clock_in,
   input  wire                 reset_in,
   input  wire                 chem_sim_pkg::seed_t seed,
   input  wire                 advance,  // Shift all lanes once
   output chem_sim_pkg::rand_t word
);
   import chem_sim_pkg::*;

   localparam int BANK_W = `CHEM_LANES * `CHEM_LANE_W;  // 128

   seed_t                 seed_ofs;   // Seed for this generator
   logic [BANK_W:1]       seed_pad;   // Zero above the top lane
   logic [`CHEM_LANE_W:1] lane [1:`CHEM_LANES];
   logic [`CHEM_LANES:1]  feed;       // New low bit per lane

   assign seed_ofs = seed + SEED_OFS;
   assign seed_pad = {1'b0, seed_ofs};

   // Feedback taps
   // Each lane mixes its bit 7 with bit 8 of the lane below
   always_comb
   begin
      for (int k = 1; k <= `CHEM_LANES; k++)
      begin
         if (k == 1)
            feed[k] = lane[k][`CHEM_LANE_W-1] ^ lane[`CHEM_LANES][`CHEM_LANE_W-1];  // Wrap
         else
            feed[k] = lane[k][`CHEM_LANE_W-1] ^ lane[k-1][`CHEM_LANE_W];
      end
   end

   always_ff @(posedge clock_in)
   begin
      if (reset_in)
      begin
         for (int k = 1; k <= `CHEM_LANES; k++)
         begin
            lane[k] <= seed_pad[`CHEM_LANE_W*k-(`CHEM_LANE_W-1) +: `CHEM_LANE_W];
         end
      end
      else if (advance)
      begin
         for (int k = 1; k <= `CHEM_LANES; k++)
         begin
            if (k == `CHEM_LANES)  // Top lane holds only 7 bits
               lane[k] <= {1'b0, lane[k][`CHEM_LANE_W-2:1], feed[k]};
            else
               lane[k] <= {lane[k][`CHEM_LANE_W-1:1], feed[k]};
         end
      end
   end

   // Output word, lane 1 lands in the MSB
   always_comb
   begin
      for (int i = 1; i <= `CHEM_LANES; i++)
      begin
         word[`CHEM_LANES-i] = lane[i][`CHEM_LANE_W-1];
      end
   end

endmodule

`default_nettype wire

/* design/chem_sim_pkg.sv */
`default_nettype none

`include "chem_sim_consts.svh"

package chem_sim_pkg;

   ////////////////////
   // Payload types
   ////////////////////

   typedef logic [`CHEM_CONC_W-1:0] conc_t;  // Count or rate constant k

   typedef logic [`CHEM_LANES-1:0] rand_t;   // One bit per generator lane

   typedef logic [`CHEM_SEED_W-1:0] seed_t;  // Shift register seed

   // Reactions fired in one step, 0 to 2
   typedef logic [1:0] events_t;

   ////////////////////
   // Step phases
   ////////////////////

   // One step walks through these in order
   typedef enum logic [1:0] {
      ADVANCE = 2'd0,  // Generators shift
      DRAW    = 2'd1,  // Compare and latch events
      APPLY   = 2'd2,  // Counters update
      SAMPLE  = 2'd3   // Result visible
   } step_phase_t;

endpackage

`default_nettype wire

/* design/chem_sim_consts.svh */
`ifndef CHEM_SIM_CONSTS_SVH
`define CHEM_SIM_CONSTS_SVH

////////////////////
// Datapath widths
////////////////////

`define CHEM_CONC_W 16   // Molecule counts and rate constant
`define CHEM_SEED_W 127  // Full shift register length

// Generator geometry, 16 lanes of 8 bits cover 128 bits
`define CHEM_LANES  16
`define CHEM_LANE_W 8

////////////////////
// Generator seeds
////////////////////

// Offset per generator so the four streams start apart
`define CHEM_SEED_OFS_A_CONC 0
`define CHEM_SEED_OFS_A_RATE 1000
`define CHEM_SEED_OFS_B_CONC 2000
`define CHEM_SEED_OFS_B_RATE 3000

// Cycles per simulation step
`define CHEM_PHASES 4

`endif
